//--- design/u2_ctrl_pkg.sv
/*
 * Control plane shared types: settings bus widths, setting address map
 * and the packed control words for clock generator, SERDES and ADC
 */

package u2_ctrl_pkg;

   // Settings bus geometry
   localparam int SET_ADDR_W = 8;
   localparam int SET_DATA_W = 32;

   // Front panel and board LEDs
   localparam int LED_W = 8;

   ////////////////////////////////////////////////////////////////////////////
   // Setting register map

   typedef enum logic [SET_ADDR_W-1:0] {
      SR_CLK       = 8'd0,
      SR_SER       = 8'd1,
      SR_ADC       = 8'd2,
      SR_LED       = 8'd3,
      SR_PHY       = 8'd4,
      SR_LED_SRC   = 8'd8,
      SR_IRQ_MASK  = 8'd9,
      SR_IRQ_CLR   = 8'd10,
      SR_TIME_NEXT = 8'd12
   } set_addr_e;

   // One settings write, valid while stb is high
   typedef struct packed {
      logic                  stb;
      set_addr_e             addr;
      logic [SET_DATA_W-1:0] data;
   } set_bus_t;

   ////////////////////////////////////////////////////////////////////////////
   // Control words driven to the board

   // Clock generator lines, low 5 bits of the setting word
   typedef struct packed {
      logic       clock_ready;
      logic [1:0] clk_en;
      logic [1:0] clk_sel;
   } clock_ctrl_t;

   typedef struct packed {
      logic enable;
      logic prbsen;
      logic loopen;
      logic rx_en;
   } serdes_ctrl_t;

   // Output enable and power for both ADC channels
   typedef struct packed {
      logic oe_a;
      logic on_a;
      logic oe_b;
      logic on_b;
   } adc_ctrl_t;

endpackage

//--- design/ctrl_regs.sv
/*
 * Setting register bank for clock, SERDES, ADC, PHY and LED control,
 * LED source selection and interrupt mask and clear decode
 */

`timescale 1ns/1ps

module ctrl_regs
   import u2_ctrl_pkg::*;
#(
   parameter int NUM_IRQ = 16
) (
   input  logic               dsp_clk,
   input  logic               rst_n_i,

   // Settings bus
   input  set_bus_t           set_bus_i,

   // Hardware status for the LEDs
   input  logic               clk_status_i,
   input  logic               serdes_link_up_i,

   // Board control
   output clock_ctrl_t        clock_ctrl_o,
   output serdes_ctrl_t       serdes_ctrl_o,
   output adc_ctrl_t          adc_ctrl_o,
   output logic               phy_resetn_o,
   output logic [LED_W-1:0]   leds_o,

   // To the interrupt controller
   output logic [NUM_IRQ-1:0] irq_mask_o,
   output logic [NUM_IRQ-1:0] irq_clr_o
);

   clock_ctrl_t        clock_ctrl_q;
   serdes_ctrl_t       serdes_ctrl_q;
   adc_ctrl_t          adc_ctrl_q;
   logic               phy_reset_q;
   logic [LED_W-1:0]   led_sw_q;
   logic [LED_W-1:0]   led_src_q;
   logic [NUM_IRQ-1:0] irq_mask_q;
   logic [NUM_IRQ-1:0] irq_clr_q;

   logic [LED_W-1:0]   led_hw;

   ////////////////////////////////////////////////////////////////////////////
   // Register decode

   always_ff @(posedge dsp_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         clock_ctrl_q  <= '0;
         serdes_ctrl_q <= '0;
         adc_ctrl_q    <= '0;
         phy_reset_q   <= 1'b0;
         led_sw_q      <= '0;
         led_src_q     <= '0;
         irq_mask_q    <= '0;
      end else if (set_bus_i.stb) begin
         case (set_bus_i.addr)
            SR_CLK: begin
               clock_ctrl_q <= clock_ctrl_t'(set_bus_i.data[$bits(clock_ctrl_t)-1:0]);
            end
            SR_SER: begin
               serdes_ctrl_q <= serdes_ctrl_t'(set_bus_i.data[$bits(serdes_ctrl_t)-1:0]);
            end
            SR_ADC: begin
               adc_ctrl_q <= adc_ctrl_t'(set_bus_i.data[$bits(adc_ctrl_t)-1:0]);
            end
            SR_LED: begin
               led_sw_q <= set_bus_i.data[LED_W-1:0];
            end
            SR_PHY: begin
               phy_reset_q <= set_bus_i.data[0];
            end
            SR_LED_SRC: begin
               led_src_q <= set_bus_i.data[LED_W-1:0];
            end
            SR_IRQ_MASK: begin
               irq_mask_q <= set_bus_i.data[NUM_IRQ-1:0];
            end
            // Other addresses belong to time sync or are unused
            default: begin
            end
         endcase
      end
   end

   // Clear is a single cycle pulse carrying the written bits
   always_ff @(posedge dsp_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         irq_clr_q <= '0;
      end else if (set_bus_i.stb && (set_bus_i.addr == SR_IRQ_CLR)) begin
         irq_clr_q <= set_bus_i.data[NUM_IRQ-1:0];
      end else begin
         irq_clr_q <= '0;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // LED source mux

   // Clock status on bit 1, SERDES link on bit 0
   assign led_hw = {{(LED_W-2){1'b0}}, clk_status_i, serdes_link_up_i};

   // Source bit set selects hardware, clear selects software
   assign leds_o = (led_src_q & led_hw) | (~led_src_q & led_sw_q);

   // Outputs
   assign clock_ctrl_o  = clock_ctrl_q;
   assign serdes_ctrl_o = serdes_ctrl_q;
   assign adc_ctrl_o    = adc_ctrl_q;
   assign phy_resetn_o  = ~phy_reset_q;
   assign irq_mask_o    = irq_mask_q;
   assign irq_clr_o     = irq_clr_q;

endmodule

//--- design/time_sync.sv
/*
 * PPS synchronizer with rising edge detect and the master time counter,
 * loadable from the settings bus on the next PPS edge
 */

`timescale 1ns/1ps

module time_sync
   import u2_ctrl_pkg::*;
#(
   parameter int TIME_W = 32
) (
   input  logic              dsp_clk,
   input  logic              rst_n_i,

   input  set_bus_t          set_bus_i,
   input  logic              pps_i,

   output logic [TIME_W-1:0] master_time_o,
   output logic              pps_event_o
);

   // Two synchronizer stages plus one for edge detect
   logic [2:0]        pps_q;
   logic              pps_edge;

   logic              time_wr;
   logic [TIME_W-1:0] time_next_q;
   logic              load_armed_q;
   logic [TIME_W-1:0] master_time_q;
   logic              pps_event_q;

   ////////////////////////////////////////////////////////////////////////////
   // PPS input

   always_ff @(posedge dsp_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         pps_q <= '0;
      end else begin
         pps_q <= {pps_q[1:0], pps_i};
      end
   end

   assign pps_edge = pps_q[1] & ~pps_q[2];

   always_ff @(posedge dsp_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         pps_event_q <= 1'b0;
      end else begin
         pps_event_q <= pps_edge;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Pending time load

   assign time_wr = set_bus_i.stb && (set_bus_i.addr == SR_TIME_NEXT);

   always_ff @(posedge dsp_clk) begin
      if (time_wr) begin
         time_next_q <= set_bus_i.data[TIME_W-1:0];
      end
   end

   // A write in the same cycle as the load re-arms for the next PPS
   always_ff @(posedge dsp_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         load_armed_q <= 1'b0;
      end else if (time_wr) begin
         load_armed_q <= 1'b1;
      end else if (pps_edge) begin
         load_armed_q <= 1'b0;
      end
   end

   // Master time
   always_ff @(posedge dsp_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         master_time_q <= '0;
      end else if (pps_edge && load_armed_q) begin
         master_time_q <= time_next_q;
      end else begin
         master_time_q <= master_time_q + 1'b1;
      end
   end

   assign master_time_o = master_time_q;
   assign pps_event_o   = pps_event_q;

endmodule

//--- design/irq_ctrl.sv
/*
 * Interrupt controller with sticky pending bits, mask and clear,
 * and the registered processor interrupt
 */

`timescale 1ns/1ps

module irq_ctrl #(
   parameter int NUM_IRQ = 16
) (
   input  logic               dsp_clk,
   input  logic               rst_n_i,

   input  logic [NUM_IRQ-2:0] irq_i,
   input  logic               pps_event_i,

   input  logic [NUM_IRQ-1:0] irq_mask_i,
   input  logic [NUM_IRQ-1:0] irq_clr_i,

   output logic               proc_int_o
);

   logic [NUM_IRQ-1:0] irq_src;
   logic [NUM_IRQ-1:0] pending_q;
   logic               proc_int_q;

   // PPS takes the lowest source
   assign irq_src = {irq_i, pps_event_i};

   // Pending bits hold until cleared, a new event beats the clear
   always_ff @(posedge dsp_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         pending_q <= '0;
      end else begin
         pending_q <= (pending_q & ~irq_clr_i) | irq_src;
      end
   end

   always_ff @(posedge dsp_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         proc_int_q <= 1'b0;
      end else begin
         proc_int_q <= |(pending_q & irq_mask_i);
      end
   end

   assign proc_int_o = proc_int_q;

endmodule

//--- design/u2_ctrl_core.sv
/*
 * Control plane top level: setting registers, time sync and
 * interrupt controller on the shared settings bus
 */

`timescale 1ns/1ps

module u2_ctrl_core
   import u2_ctrl_pkg::*;
#(
   parameter int NUM_IRQ = 16,
   parameter int TIME_W  = 32
) (
   input  logic               dsp_clk,
   input  logic               rst_n_i,

   // Host settings writes
   input  set_bus_t           set_bus_i,

   // Board inputs
   input  logic               pps_i,
   input  logic [NUM_IRQ-2:0] irq_i,
   input  logic               clk_status_i,
   input  logic               serdes_link_up_i,

   // Board control
   output clock_ctrl_t        clock_ctrl_o,
   output serdes_ctrl_t       serdes_ctrl_o,
   output adc_ctrl_t          adc_ctrl_o,
   output logic               phy_resetn_o,
   output logic [LED_W-1:0]   leds_o,

   // Time and processor interrupt
   output logic [TIME_W-1:0]  master_time_o,
   output logic               proc_int_o
);

   logic [NUM_IRQ-1:0] irq_mask;
   logic [NUM_IRQ-1:0] irq_clr;
   logic               pps_event;

   ////////////////////////////////////////////////////////////////////////////
   // Setting registers

   ctrl_regs #(
      .NUM_IRQ (NUM_IRQ)
   ) ctrl_regs_i (
      .dsp_clk          (dsp_clk),
      .rst_n_i          (rst_n_i),
      .set_bus_i        (set_bus_i),
      .clk_status_i     (clk_status_i),
      .serdes_link_up_i (serdes_link_up_i),
      .clock_ctrl_o     (clock_ctrl_o),
      .serdes_ctrl_o    (serdes_ctrl_o),
      .adc_ctrl_o       (adc_ctrl_o),
      .phy_resetn_o     (phy_resetn_o),
      .leds_o           (leds_o),
      .irq_mask_o       (irq_mask),
      .irq_clr_o        (irq_clr)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Master time

   time_sync #(
      .TIME_W (TIME_W)
   ) time_sync_i (
      .dsp_clk       (dsp_clk),
      .rst_n_i       (rst_n_i),
      .set_bus_i     (set_bus_i),
      .pps_i         (pps_i),
      .master_time_o (master_time_o),
      .pps_event_o   (pps_event)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Interrupts, PPS on source 0

   irq_ctrl #(
      .NUM_IRQ (NUM_IRQ)
   ) irq_ctrl_i (
      .dsp_clk     (dsp_clk),
      .rst_n_i     (rst_n_i),
      .irq_i       (irq_i),
      .pps_event_i (pps_event),
      .irq_mask_i  (irq_mask),
      .irq_clr_i   (irq_clr),
      .proc_int_o  (proc_int_o)
   );

endmodule

//--- dv/u2_ctrl_tasks.svh
/*
 * Testbench tasks: settings bus writes, PPS and interrupt pulses,
 * and the expected-value bookkeeping behind the output checkers
 */

task automatic wait_cycles(input int n);
   repeat (n) @(posedge dsp_clk);
endtask

// Shadow of the setting registers, updated at the edge that takes the write
task automatic note_write(input set_addr_e addr, input logic [SET_DATA_W-1:0] data);
   case (addr)
      SR_CLK:       exp_clk = clock_ctrl_t'(data[4:0]);
      SR_SER:       exp_ser = serdes_ctrl_t'(data[3:0]);
      SR_ADC:       exp_adc = adc_ctrl_t'(data[3:0]);
      SR_LED:       exp_led_sw = data[LED_W-1:0];
      SR_PHY:       exp_phy_resetn = ~data[0];
      SR_LED_SRC:   exp_led_src = data[LED_W-1:0];
      SR_TIME_NEXT: begin
         time_next_val = data[TIME_W-1:0];
         time_armed    = 1'b1;
      end
      // Mask, clear and unused addresses leave the board outputs alone
      default: begin
      end
   endcase
endtask

task automatic write_setting(input set_addr_e addr, input logic [SET_DATA_W-1:0] data);
   @(posedge dsp_clk);
   set_bus_i <= {1'b1, addr, data};
   // Edge k samples the strobe
   @(posedge dsp_clk);
   set_bus_i.stb <= 1'b0;
   note_write(addr, data);
endtask

// Single cycle pulse on source src, 1 up to NUM_IRQ-1
task automatic pulse_irq(input int src);
   logic [NUM_IRQ-2:0] one_hot;
   one_hot = '0;
   one_hot[src-1] = 1'b1;
   @(posedge dsp_clk);
   irq_i <= one_hot;
   @(posedge dsp_clk);
   irq_i <= '0;
endtask

task automatic pulse_pps(input logic raise_int);
   @(posedge dsp_clk);
   pps_i <= 1'b1;
   // Edges p, p+1 and p+2
   repeat (3) @(posedge dsp_clk);
   if (time_armed) begin
      time_load_val  = time_next_val;
      time_load_pend = 1'b1;
      time_armed     = 1'b0;
   end
   @(posedge dsp_clk);
   pps_i <= 1'b0;
   // Event at p+2, pending at p+3, processor interrupt at p+4
   @(posedge dsp_clk);
   if (raise_int) begin
      exp_proc_int = 1'b1;
   end
   // Synchronizer back to low before any further pulse
   repeat (3) @(posedge dsp_clk);
endtask

//--- dv/u2_ctrl_tb.sv
/*
 * Control plane testbench: clock, reset, DUT, output checkers,
 * timeout and the test sequence
 */

`timescale 1ns/1ps

module u2_ctrl_tb
   import u2_ctrl_pkg::*;
();

   localparam int NUM_IRQ        = 16;
   localparam int TIME_W         = 32;
   localparam int CLK_PERIOD     = 40;
   localparam int RESET_CYCLES   = 8;
   localparam int TIMEOUT_CYCLES = 2000;

   logic               dsp_clk;
   logic               rst_n_i;
   set_bus_t           set_bus_i;
   logic               pps_i;
   logic [NUM_IRQ-2:0] irq_i;
   logic               clk_status_i;
   logic               serdes_link_up_i;

   clock_ctrl_t        clock_ctrl_o;
   serdes_ctrl_t       serdes_ctrl_o;
   adc_ctrl_t          adc_ctrl_o;
   logic               phy_resetn_o;
   logic [LED_W-1:0]   leds_o;
   logic [TIME_W-1:0]  master_time_o;
   logic               proc_int_o;

   // Expected state
   clock_ctrl_t        exp_clk        = '0;
   serdes_ctrl_t       exp_ser        = '0;
   adc_ctrl_t          exp_adc        = '0;
   logic               exp_phy_resetn = 1'b1;
   logic [LED_W-1:0]   exp_led_sw     = '0;
   logic [LED_W-1:0]   exp_led_src    = '0;
   logic               exp_proc_int   = 1'b0;
   logic [TIME_W-1:0]  exp_time       = '0;
   logic               time_live      = 1'b0;
   logic [TIME_W-1:0]  time_next_val  = '0;
   logic               time_armed     = 1'b0;
   logic [TIME_W-1:0]  time_load_val  = '0;
   logic               time_load_pend = 1'b0;

   string              test_name;
   integer             seed = 32'h2a60_840b;
   logic [31:0]        rnd;
   int                 cycle_cnt = 0;

   `include "u2_ctrl_tasks.svh"

   u2_ctrl_core #(
      .NUM_IRQ (NUM_IRQ),
      .TIME_W  (TIME_W)
   ) dut_i (
      .dsp_clk          (dsp_clk),
      .rst_n_i          (rst_n_i),
      .set_bus_i        (set_bus_i),
      .pps_i            (pps_i),
      .irq_i            (irq_i),
      .clk_status_i     (clk_status_i),
      .serdes_link_up_i (serdes_link_up_i),
      .clock_ctrl_o     (clock_ctrl_o),
      .serdes_ctrl_o    (serdes_ctrl_o),
      .adc_ctrl_o       (adc_ctrl_o),
      .phy_resetn_o     (phy_resetn_o),
      .leds_o           (leds_o),
      .master_time_o    (master_time_o),
      .proc_int_o       (proc_int_o)
   );

   initial begin
      dsp_clk = 1'b0;
      forever #(CLK_PERIOD/2) dsp_clk = ~dsp_clk;
   end

   task automatic fail_value(input string what, input logic [31:0] exp_val,
                             input logic [31:0] act_val);
      $display("FAIL %s %s: expected 0x%0h, actual 0x%0h", test_name, what, exp_val, act_val);
      $display("Test FAILED");
      $fatal(1, "Stopped at the first mismatch");
   endtask

   // Hardware bit where the source bit is set, software bit elsewhere
   function automatic logic [LED_W-1:0] expected_leds(input logic [LED_W-1:0] sw,
                                                      input logic [LED_W-1:0] src,
                                                      input logic clk_st, input logic link);
      logic [LED_W-1:0] hw;
      logic [LED_W-1:0] leds;
      hw = '0;
      hw[1] = clk_st;
      hw[0] = link;
      for (int i = 0; i < LED_W; i++) begin
         leds[i] = src[i] ? hw[i] : sw[i];
      end
      return leds;
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // Output checkers, sampled mid-cycle

   always @(negedge dsp_clk) begin
      assert (clock_ctrl_o == exp_clk) else fail_value("clock_ctrl_o", exp_clk, clock_ctrl_o);
      assert (serdes_ctrl_o == exp_ser) else fail_value("serdes_ctrl_o", exp_ser, serdes_ctrl_o);
      assert (adc_ctrl_o == exp_adc) else fail_value("adc_ctrl_o", exp_adc, adc_ctrl_o);
      assert (phy_resetn_o == exp_phy_resetn)
         else fail_value("phy_resetn_o", exp_phy_resetn, phy_resetn_o);
      assert (leds_o == expected_leds(exp_led_sw, exp_led_src, clk_status_i, serdes_link_up_i))
         else fail_value("leds_o",
                         expected_leds(exp_led_sw, exp_led_src, clk_status_i, serdes_link_up_i),
                         leds_o);
      assert (proc_int_o == exp_proc_int) else fail_value("proc_int_o", exp_proc_int, proc_int_o);
   end

   // Master time counts every edge after reset unless a PPS load lands
   always @(negedge dsp_clk) begin
      if (!rst_n_i) begin
         exp_time  = '0;
         time_live = 1'b0;
      end else if (!time_live) begin
         time_live = 1'b1;
      end else if (time_load_pend) begin
         exp_time       = time_load_val;
         time_load_pend = 1'b0;
      end else begin
         exp_time = exp_time + 1'b1;
      end
      assert (master_time_o == exp_time) else fail_value("master_time_o", exp_time, master_time_o);
   end

   always @(posedge dsp_clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         $display("Timeout: the test sequence did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("Test FAILED");
         $fatal(1, "Timeout");
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Test sequence

   initial begin
      rst_n_i          = 1'b0;
      set_bus_i        = '0;
      pps_i            = 1'b0;
      irq_i            = '0;
      clk_status_i     = 1'b0;
      serdes_link_up_i = 1'b0;
      test_name        = "reset";
      wait_cycles(RESET_CYCLES);
      rst_n_i <= 1'b1;
      wait_cycles(4);

      test_name = "reg_write";
      repeat (4) begin
         rnd = $random(seed);
         write_setting(SR_CLK, rnd);
         rnd = $random(seed);
         write_setting(SR_SER, rnd);
         rnd = $random(seed);
         write_setting(SR_ADC, rnd);
         rnd = $random(seed);
         write_setting(SR_PHY, rnd);
      end
      test_name = "unused_addr";
      rnd = $random(seed);
      write_setting(set_addr_e'(8'd5), rnd);
      write_setting(set_addr_e'(8'd11), ~rnd);
      write_setting(set_addr_e'(8'hff), rnd);
      wait_cycles(2);

      test_name = "led_mux";
      repeat (10) begin
         rnd = $random(seed);
         write_setting(SR_LED, rnd);
         rnd = $random(seed);
         write_setting(SR_LED_SRC, rnd);
         rnd = $random(seed);
         @(posedge dsp_clk);
         clk_status_i     <= rnd[0];
         serdes_link_up_i <= rnd[1];
         wait_cycles(2);
      end

      test_name = "master_time";
      pulse_pps(1'b0);
      rnd = $random(seed);
      write_setting(SR_TIME_NEXT, rnd);
      wait_cycles(3);
      pulse_pps(1'b0);
      wait_cycles(10);
      pulse_pps(1'b0);
      wait_cycles(5);

      // Drop the PPS events left pending while the mask was clear
      test_name = "interrupts";
      write_setting(SR_IRQ_CLR, '1);
      wait_cycles(2);
      pulse_irq(4);
      wait_cycles(6);
      write_setting(SR_IRQ_MASK, 32'h10);
      @(posedge dsp_clk);
      exp_proc_int = 1'b1;
      wait_cycles(3);
      write_setting(SR_IRQ_CLR, 32'h10);
      wait_cycles(2);
      exp_proc_int = 1'b0;
      wait_cycles(3);

      test_name = "pps_irq";
      write_setting(SR_IRQ_MASK, 32'h1);
      pulse_pps(1'b1);
      write_setting(SR_IRQ_CLR, 32'h1);
      wait_cycles(2);
      exp_proc_int = 1'b0;
      wait_cycles(4);

      $display("Test OK");
      $finish;
   end

endmodule

//--- project.f
+incdir+dv
design/u2_ctrl_pkg.sv
design/ctrl_regs.sv
design/time_sync.sv
design/irq_ctrl.sv
design/u2_ctrl_core.sv
dv/u2_ctrl_tb.sv
